//--- verilog/mul_pkg.sv
/*
  Shared types for the two-stage multiply unit.
  Import this package into any module that handles requests, stage data or products.
*/

package mul_pkg;

  // ==========================================================
  // Basic word types
  // ==========================================================

  // Operand and result word of the integer core
  typedef logic [31:0] mul_word_t;

  // Full double-width product
  typedef logic [63:0] mul_prod_t;

  // ==========================================================
  // Opcodes and pipeline structs
  // ==========================================================

  // The low word does not depend on signedness, so it has one opcode only
  typedef enum logic [1:0] {
    MUL_LO    = 2'd0,
    MUL_HI_SS = 2'd1,
    MUL_HI_SU = 2'd2,
    MUL_HI_UU = 2'd3
  } mul_op_e;

  // Request as it arrives at the top level
  typedef struct packed {
    mul_op_e   op;
    mul_word_t a;
    mul_word_t b;
  } mul_req_t;

  // Operands after sign removal, plus the sign to apply to the product
  typedef struct packed {
    mul_op_e   op;
    mul_word_t a_mag;
    mul_word_t b_mag;
    logic      neg;
  } mul_stage_t;

endpackage

//--- verilog/mult16x16combo.sv
/*
  Combinational 16x16 unsigned multiplier using one Karatsuba step.
  Only the three 8x8 partial products use the multiply operator.
*/

`timescale 1ns/1ps

module mult16x16combo (
  input  logic [15:0] a,
  input  logic [15:0] b,
  output logic [31:0] o
);

  // Half differences carry one extra bit for the sign
  logic [8:0]  a_diff;
  logic [8:0]  b_diff;
  logic [7:0]  a_abs;
  logic [7:0]  b_abs;
  logic        diff_neg;
  logic [15:0] z2;
  logic [15:0] z0;
  logic [15:0] p_abs;
  // The middle term is a1*b0 + a0*b1, which needs 17 bits
  logic [16:0] p_sgn;
  logic [16:0] z1;

  // Low half minus high half of a, high half minus low half of b
  assign a_diff = {1'b0, a[7:0]} - {1'b0, a[15:8]};
  assign b_diff = {1'b0, b[15:8]} - {1'b0, b[7:0]};

  // Magnitudes always fit in 8 bits, even for a difference of -255
  assign a_abs = a_diff[8] ? 8'(-a_diff) : a_diff[7:0];
  assign b_abs = b_diff[8] ? 8'(-b_diff) : b_diff[7:0];

  // The difference product is negative when exactly one difference is
  assign diff_neg = a_diff[8] ^ b_diff[8];

  // The three 8x8 products
  assign z2    = a[15:8] * b[15:8];
  assign z0    = a[7:0] * b[7:0];
  assign p_abs = a_abs * b_abs;

  // Restore the sign of the difference product in the middle-term width
  assign p_sgn = diff_neg ? -{1'b0, p_abs} : {1'b0, p_abs};

  // Modulo 2^17 arithmetic is exact here since the true sum is non-negative
  // and below 2^17
  assign z1 = {1'b0, z2} + {1'b0, z0} + p_sgn;

  // High and low products side by side, middle term shifted by one half
  assign o = {z2, z0} + {7'd0, z1, 8'd0};

endmodule

//--- verilog/mult32x32combo.sv
/*
  Combinational 32x32 unsigned Karatsuba multiplier.
  Three 16x16 Karatsuba multipliers form the high, low and difference products.
  Feed it magnitudes and apply any sign to the 64-bit result outside.
*/

`timescale 1ns/1ps

module mult32x32combo import mul_pkg::*; (
  input  mul_word_t a,
  input  mul_word_t b,
  output mul_prod_t o
);

  // ==========================================================
  // Half differences
  // ==========================================================

  // One extra bit holds the sign of each 16-bit difference
  logic [16:0] a_diff;
  logic [16:0] b_diff;
  logic [15:0] a_abs;
  logic [15:0] b_abs;
  logic        diff_neg;

  // x0 - x1 for a, y1 - y0 for b, so that z1 = z2 + z0 + product
  assign a_diff = {1'b0, a[15:0]} - {1'b0, a[31:16]};
  assign b_diff = {1'b0, b[31:16]} - {1'b0, b[15:0]};

  // The largest magnitude is 0xFFFF, which still fits in 16 bits
  assign a_abs = a_diff[16] ? 16'(-a_diff) : a_diff[15:0];
  assign b_abs = b_diff[16] ? 16'(-b_diff) : b_diff[15:0];

  assign diff_neg = a_diff[16] ^ b_diff[16];

  // ==========================================================
  // Partial products
  // ==========================================================

  logic [31:0] z2;
  logic [31:0] z0;
  logic [31:0] p_abs;

  // z2 is the product of the high halves
  mult16x16combo u_mul_hi (
    .a (a[31:16]),
    .b (b[31:16]),
    .o (z2)
  );

  // z0 is the product of the low halves
  mult16x16combo u_mul_lo (
    .a (a[15:0]),
    .b (b[15:0]),
    .o (z0)
  );

  // Product of the two difference magnitudes
  mult16x16combo u_mul_mid (
    .a (a_abs),
    .b (b_abs),
    .o (p_abs)
  );

  // ==========================================================
  // Recombination
  // ==========================================================

  logic [32:0] p_sgn;
  // Middle term x1*y0 + x0*y1 can reach bit 32, hence 33 bits
  logic [32:0] z1;

  assign p_sgn = diff_neg ? -{1'b0, p_abs} : {1'b0, p_abs};

  // Wraparound in 33 bits cancels out because the true value is non-negative
  assign z1 = {1'b0, z2} + {1'b0, z0} + p_sgn;

  assign o = {z2, z0} + {15'd0, z1, 16'd0};

endmodule

//--- verilog/mul_operand_stage.sv
/*
  First pipeline stage of the multiply unit.
  Decodes the opcode, strips the sign from signed operands and registers
  the magnitudes, the product sign, the opcode, the tag and the valid bit.
*/

`timescale 1ns/1ps

module mul_operand_stage import mul_pkg::*; #(
  parameter int TAG_W = 4
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             req_valid,
  input  mul_req_t         req,
  input  logic [TAG_W-1:0] req_tag,
  output logic             stage_valid,
  output mul_stage_t       stage,
  output logic [TAG_W-1:0] stage_tag
);

  logic       a_signed;
  logic       b_signed;
  logic       a_neg;
  logic       b_neg;
  mul_stage_t stage_d;

  // a is signed for both signed high-word forms, b only for signed by signed
  assign a_signed = (req.op == MUL_HI_SS) || (req.op == MUL_HI_SU);
  assign b_signed = (req.op == MUL_HI_SS);

  // An operand is only negative when it is treated as signed
  assign a_neg = a_signed & req.a[31];
  assign b_neg = b_signed & req.b[31];

  // Build the next stage word
  always_comb begin
    stage_d.op    = req.op;
    // The most negative value maps to 2^31, which is still correct unsigned
    stage_d.a_mag = a_neg ? -req.a : req.a;
    stage_d.b_mag = b_neg ? -req.b : req.b;
    stage_d.neg   = a_neg ^ b_neg;
  end

  // Registers load on every edge; valid tells the next stage what is real
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage_valid <= 1'b0;
      stage       <= '0;
      stage_tag   <= '0;
    end else begin
      stage_valid <= req_valid;
      stage       <= stage_d;
      stage_tag   <= req_tag;
    end
  end

endmodule

//--- verilog/mul_result_stage.sv
/*
  Second pipeline stage of the multiply unit.
  Applies the sign to the core product, picks the low or high word
  and registers the response with its tag.
*/

`timescale 1ns/1ps

module mul_result_stage import mul_pkg::*; #(
  parameter int TAG_W = 4
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             stage_valid,
  input  mul_stage_t       stage,
  input  logic [TAG_W-1:0] stage_tag,
  input  mul_prod_t        prod,
  output logic             resp_valid,
  output mul_word_t        resp_result,
  output logic [TAG_W-1:0] resp_tag
);

  mul_prod_t prod_sgn;
  mul_word_t result_d;

  // Negating the full 64-bit product gives the two's complement result
  assign prod_sgn = stage.neg ? -prod : prod;

  // Word selection by opcode
  always_comb begin
    case (stage.op)
      MUL_LO:  result_d = prod_sgn[31:0];
      // All three high-word forms differ only in the sign handling above
      default: result_d = prod_sgn[63:32];
    endcase
  end

  // Response registers, valid for exactly one cycle per request
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_valid  <= 1'b0;
      resp_result <= '0;
      resp_tag    <= '0;
    end else begin
      resp_valid  <= stage_valid;
      resp_result <= result_d;
      resp_tag    <= stage_tag;
    end
  end

endmodule

//--- verilog/mul_unit.sv
/*
  Two-stage multiply unit with a fixed latency of two cycles.
  Accepts one request per cycle and returns results in order with their tags.
*/

`timescale 1ns/1ps

module mul_unit import mul_pkg::*; #(
  parameter int TAG_W = 4
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             req_valid,
  input  mul_req_t         req,
  input  logic [TAG_W-1:0] req_tag,
  output logic             resp_valid,
  output mul_word_t        resp_result,
  output logic [TAG_W-1:0] resp_tag
);

  logic             stage_valid;
  mul_stage_t       stage;
  logic [TAG_W-1:0] stage_tag;
  mul_prod_t        prod;

  // Cycle 1 registers magnitudes and the sign
  mul_operand_stage #(
    .TAG_W (TAG_W)
  ) i_operand_stage (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid   (req_valid),
    .req         (req),
    .req_tag     (req_tag),
    .stage_valid (stage_valid),
    .stage       (stage),
    .stage_tag   (stage_tag)
  );

  // Unsigned Karatsuba core between the two register stages
  mult32x32combo i_mult (
    .a (stage.a_mag),
    .b (stage.b_mag),
    .o (prod)
  );

  // Cycle 2 applies the sign and registers the selected word
  mul_result_stage #(
    .TAG_W (TAG_W)
  ) i_result_stage (
    .clk         (clk),
    .rst_n       (rst_n),
    .stage_valid (stage_valid),
    .stage       (stage),
    .stage_tag   (stage_tag),
    .prod        (prod),
    .resp_valid  (resp_valid),
    .resp_result (resp_result),
    .resp_tag    (resp_tag)
  );

endmodule

//--- tests/mul_unit_chk.sv
/*
  Assertions on the valid and tag pipeline of the multiply unit.
  Bound into every mul_unit instance.
*/

`timescale 1ns/1ps

module mul_unit_chk #(
  parameter int TAG_W = 4
) (
  input logic             clk,
  input logic             rst_n,
  input logic             stage_valid,
  input logic [TAG_W-1:0] stage_tag,
  input logic             resp_valid,
  input logic [TAG_W-1:0] resp_tag
);

  // Number of failed assertions over the whole run
  int fail_count = 0;

  // Every staged request leaves on the next edge
  a_stage_to_resp: assert property (@(posedge clk) disable iff (!rst_n)
    stage_valid |=> resp_valid)
    else begin
      $error("stage_valid was not followed by resp_valid");
      fail_count++;
    end

  // A response needs a staged request one cycle earlier
  a_resp_has_stage: assert property (@(posedge clk) disable iff (!rst_n)
    resp_valid |-> $past(stage_valid))
    else begin
      $error("resp_valid without stage_valid one cycle earlier");
      fail_count++;
    end

  a_tag_follows: assert property (@(posedge clk) disable iff (!rst_n)
    resp_valid |-> resp_tag == $past(stage_tag))
    else begin
      $error("resp_tag differs from the previous stage_tag");
      fail_count++;
    end

  a_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !resp_valid)
    else begin
      $error("resp_valid high during reset");
      fail_count++;
    end

endmodule

bind mul_unit mul_unit_chk #(
  .TAG_W (TAG_W)
) i_mul_unit_chk (
  .clk         (clk),
  .rst_n       (rst_n),
  .stage_valid (stage_valid),
  .stage_tag   (stage_tag),
  .resp_valid  (resp_valid),
  .resp_tag    (resp_tag)
);

//--- tests/tb_mul_unit.sv
/*
  Directed testbench for the two-stage multiply unit.
  Requests are issued on rising edges, and a queue of predicted responses
  is compared against result, tag and arrival cycle of each response.
*/

`timescale 1ns/1ps

module tb_mul_unit import mul_pkg::*; ();

  localparam int TAG_W      = 4;
  localparam int CLK_PERIOD = 8;
  localparam int N_CORNER   = 4 * 5 * 5;
  localparam int N_KARA     = 4 * 8 * 8;
  localparam int N_B2B      = 200;
  localparam int N_GAP      = 100;
  localparam int MAX_GAP    = 3;
  // Each gapped request can be followed by up to MAX_GAP idle slots
  localparam int RUN_CYCLES = N_CORNER + N_KARA + N_B2B + N_GAP * (1 + MAX_GAP) + 100;
  // Driven at edge k, sampled by the DUT at k+1, resp_valid rises at k+2, seen at k+3
  localparam int SEEN_LAT   = 3;

  // Predicted response, queued when its request is driven
  typedef struct packed {
    mul_word_t        result;
    logic [TAG_W-1:0] tag;
    logic [31:0]      cycle;
  } expect_t;

  logic             clk;
  logic             rst_n;
  logic             req_valid;
  mul_req_t         req;
  logic [TAG_W-1:0] req_tag;
  logic             resp_valid;
  mul_word_t        resp_result;
  logic [TAG_W-1:0] resp_tag;

  expect_t          exp_q[$];
  string            test_name;
  logic [31:0]      cycle;
  logic [TAG_W-1:0] tag_cnt;
  int               value_errors;
  int               protocol_errors;
  int               assert_errors;

  mul_unit #(
    .TAG_W (TAG_W)
  ) i_mul_unit (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid   (req_valid),
    .req         (req),
    .req_tag     (req_tag),
    .resp_valid  (resp_valid),
    .resp_result (resp_result),
    .resp_tag    (resp_tag)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // Run limit covering every request slot plus a margin
  initial begin
    #(RUN_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not complete within %0d cycles", RUN_CYCLES);
    $display("Finished with errors");
    $finish;
  end

  // ============================================================
  // Reference model and compare tasks
  // ============================================================

  // Extend each operand by its own sign rule so that the low 64 product bits are exact
  function automatic mul_word_t reference_mul(mul_op_e op, mul_word_t a, mul_word_t b);
    logic [63:0] a_ext;
    logic [63:0] b_ext;
    logic [63:0] prod;
    a_ext = (op == MUL_HI_SS || op == MUL_HI_SU) ? {{32{a[31]}}, a} : {32'd0, a};
    b_ext = (op == MUL_HI_SS) ? {{32{b[31]}}, b} : {32'd0, b};
    prod  = a_ext * b_ext;
    return (op == MUL_LO) ? prod[31:0] : prod[63:32];
  endfunction

  task automatic check_result(string name, mul_word_t exp, mul_word_t act);
    if (exp !== act) begin
      value_errors++;
      $display("FAILED %s result: expected %08h, actual %08h", name, exp, act);
    end
  endtask

  task automatic check_tag(string name, logic [TAG_W-1:0] exp, logic [TAG_W-1:0] act);
    if (exp !== act) begin
      value_errors++;
      $display("FAILED %s tag: expected %0h, actual %0h", name, exp, act);
    end
  endtask

  task automatic check_latency(string name, int exp, int act);
    if (exp != act) begin
      value_errors++;
      $display("FAILED %s latency in edges: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  // Responses are taken from the values that held during the cycle before the edge
  always @(posedge clk) begin
    if (!rst_n && resp_valid !== 1'b0) begin
      protocol_errors++;
      $display("resp_valid was not low while reset was asserted");
    end else if (resp_valid && exp_q.size() == 0) begin
      protocol_errors++;
      $display("%s: response with tag %0h arrived with no request", test_name, resp_tag);
    end else if (resp_valid) begin
      check_result(test_name, exp_q[0].result, resp_result);
      check_tag(test_name, exp_q[0].tag, resp_tag);
      check_latency(test_name, SEEN_LAT, cycle - exp_q[0].cycle);
      void'(exp_q.pop_front());
    end
  end

  // ============================================================
  // Drivers
  // ============================================================

  task automatic issue_request(mul_op_e op, mul_word_t a, mul_word_t b);
    @(posedge clk);
    req_valid <= 1'b1;
    req.op    <= op;
    req.a     <= a;
    req.b     <= b;
    req_tag   <= tag_cnt;
    exp_q.push_back({reference_mul(op, a, b), tag_cnt, cycle});
    // Consecutive tags, so every request in flight has its own
    tag_cnt = tag_cnt + 1'b1;
  endtask

  task automatic idle_cycles(int n);
    repeat (n) begin
      @(posedge clk);
      req_valid <= 1'b0;
    end
  endtask

  // Waits for all predicted responses, giving up after twice the latency
  task automatic drain_responses();
    int waited;
    waited = 0;
    idle_cycles(1);
    while (exp_q.size() != 0 && waited < 2 * SEEN_LAT) begin
      @(posedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      protocol_errors += exp_q.size();
      $display("%s: %0d expected responses never arrived", test_name, exp_q.size());
      exp_q.delete();
    end
  endtask

  // Zero, one, all ones, most negative, most positive
  function automatic mul_word_t corner_value(int i);
    case (i)
      0:       return 32'h0000_0000;
      1:       return 32'h0000_0001;
      2:       return 32'hFFFF_FFFF;
      3:       return 32'h8000_0000;
      default: return 32'h7FFF_FFFF;
    endcase
  endfunction

  // Half and sub-half extremes that flip the sign of the half differences
  function automatic mul_word_t kara_value(int i);
    case (i)
      0:       return 32'hFFFF_0001;
      1:       return 32'h0001_FFFF;
      2:       return 32'hFFFF_FFFF;
      3:       return 32'h0001_0001;
      4:       return 32'hFF00_FF00;
      5:       return 32'h00FF_00FF;
      6:       return 32'hFF00_00FF;
      default: return 32'h00FF_FF00;
    endcase
  endfunction

  // ============================================================
  // Tests
  // ============================================================

  // Any response here is caught by the monitor as one without a request
  task automatic reset_idle();
    test_name = "reset_idle";
    idle_cycles(10);
  endtask

  task automatic corner_operands();
    test_name = "corner_operands";
    for (int o = 0; o < 4; o++)
      for (int i = 0; i < 5; i++)
        for (int j = 0; j < 5; j++)
          issue_request(mul_op_e'(o), corner_value(i), corner_value(j));
    drain_responses();
  endtask

  task automatic karatsuba_carries();
    test_name = "karatsuba_carries";
    for (int o = 0; o < 4; o++)
      for (int i = 0; i < 8; i++)
        for (int j = 0; j < 8; j++)
          issue_request(mul_op_e'(o), kara_value(i), kara_value(j));
    drain_responses();
  endtask

  task automatic back_to_back();
    test_name = "back_to_back";
    for (int i = 0; i < N_B2B; i++)
      issue_request(mul_op_e'($urandom_range(3, 0)), $urandom, $urandom);
    drain_responses();
  endtask

  // The latency check on each response shows it did not drift into an idle slot
  task automatic gapped_stream();
    test_name = "gapped_stream";
    for (int i = 0; i < N_GAP; i++) begin
      issue_request(mul_op_e'($urandom_range(3, 0)), $urandom, $urandom);
      idle_cycles($urandom_range(MAX_GAP, 0));
    end
    drain_responses();
  endtask

  initial begin
    void'($urandom(20));
    rst_n           <= 1'b0;
    req_valid       = 1'b0;
    req             = '0;
    req_tag         = '0;
    tag_cnt         = '0;
    cycle           = '0;
    value_errors    = 0;
    protocol_errors = 0;
    assert_errors   = 0;
    test_name       = "reset";
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    reset_idle();
    corner_operands();
    karatsuba_carries();
    back_to_back();
    gapped_stream();
    assert_errors = i_mul_unit.i_mul_unit_chk.fail_count;
    $display("Errors: %0d value mismatches, %0d protocol errors, %0d assertion failures",
             value_errors, protocol_errors, assert_errors);
    if (value_errors == 0 && protocol_errors == 0 && assert_errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

//--- tb.f
verilog/mul_pkg.sv
verilog/mult16x16combo.sv
verilog/mult32x32combo.sv
verilog/mul_operand_stage.sv
verilog/mul_result_stage.sv
verilog/mul_unit.sv
tests/mul_unit_chk.sv
tests/tb_mul_unit.sv

//--- Bender.yml
package:
  name: mul_unit

sources:
  - files:
      - verilog/mul_pkg.sv
      - verilog/mult16x16combo.sv
      - verilog/mult32x32combo.sv
      - verilog/mul_operand_stage.sv
      - verilog/mul_result_stage.sv
      - verilog/mul_unit.sv
  - target: test
    files:
      - tests/mul_unit_chk.sv
      - tests/tb_mul_unit.sv
